/* cpu_datapath.f */
logic/rv32i_types.sv
logic/cpu_fetch.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_memory.sv
logic/cpu_datapath.sv
verification/cpu_datapath_checker.sv
verification/cpu_datapath_tb.sv

/* Bender.yml */
package:
  name: cpu_datapath

sources:
  - logic/rv32i_types.sv
  - logic/cpu_fetch.sv
  - logic/cpu_decode.sv
  - logic/cpu_execute.sv
  - logic/cpu_memory.sv
  - logic/cpu_datapath.sv
  - target: test
    files:
      - verification/cpu_datapath_checker.sv
      - verification/cpu_datapath_tb.sv

/* verification/cpu_datapath_tb.sv */
module cpu_datapath_tb import rv32i_types::*; ();

	localparam int n_instr = 200;
	localparam int period = 40;
	localparam int time_limit = n_instr * 4 * 3 * period;

	logic clk, rst_n;
	logic resp_a, resp_b;
	logic [31:0] rdata_a, rdata_b;
	logic read_a, read_b, write;
	logic [3:0] wmask;
	logic [31:0] address_a, address_b, wdata;
	logic [31:0] imem [256];
	logic [31:0] dmem [64];
	integer seed;
	int idx, a_wait, b_wait, errors;
	logic a_held, data_busy, done;

	cpu_datapath #(
		.pc_reset(32'h0000_0000)
	) u_cpu_datapath (
		.clk, .rst_n, .resp_a, .resp_b, .rdata_a, .rdata_b,
		.read_a, .read_b, .write, .wmask, .address_a, .address_b, .wdata
	);

	cpu_datapath_checker #(
		.n_instr(n_instr)
	) u_checker (
		.clk, .rst_n, .read_a, .address_a, .read_b, .write, .resp_b, .wmask,
		.address_b, .wdata, .errors, .done
	);

	always #(period / 2) clk = ~clk;

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] r_type(input int f3, input int sub, input int rd,
		input int rs1, input int rs2);
		return {1'b0, sub[0], 5'd0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input int f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3_word, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_br};
	endfunction

	function automatic logic [31:0] u_type(input int rd, input int imm);
		return {imm[19:0], rd[4:0], op_lui};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[idx] = word;
		idx++;
	endtask

	task automatic build_program();
		int i, kind, rd, rs, rt, f3, word;
		int used [$];
		for (i = 0; i < 256; i++)
			imem[i] = nop_instr;
		idx = 0;
		while (idx < n_instr - 4) begin
			kind = random_below(7);
			rd = 1 + random_below(7);
			rs = random_below(8);
			rt = random_below(8);
			f3 = random_below(8);
			// sltu is outside the subset
			if (f3 == 3)
				f3 = 0;
			case (kind)
				0, 1: emit(r_type(f3, (f3 == 0) ? random_below(2) : 0, rd, rs, rt));
				2, 3: emit(i_type(op_imm, f3, rd, rs,
					(f3 == 1 || f3 == 5) ? random_below(32) : random_below(4096)));
				4: emit(u_type(rd, random_below(1 << 20)));
				5: begin
					word = random_below(64);
					if (used.size() > 0)
						word = used[random_below(used.size())];
					emit(i_type(op_load, f3_word, rd, 0, word * 4));
					if (random_below(2) == 1) begin
						rs = rd;
						rd = 1 + random_below(7);
						emit(r_type(f3, 0, rd, rs, rt));
					end
				end
				default: emit(b_type(random_below(2), rs, rt, (2 + random_below(3)) * 4));
			endcase
			if (kind != 6) begin
				word = random_below(64);
				emit(s_type(rd, 0, word * 4));
				used.push_back(word);
			end
		end
		while (idx < n_instr - 1)
			emit(nop_instr);
		// Self-loop that parks the core
		emit(b_type(f3_beq, 0, 0, 0));
	endtask

	// A held instruction keeps the fetch port quiet until it moves on
	always @(posedge clk) begin
		data_busy = (read_b || write) && !resp_b;
		if (!rst_n) begin
			resp_a <= 1'b0;
			resp_b <= 1'b0;
			a_held = 1'b0;
			a_wait = 0;
			b_wait = 0;
		end else begin
			if (resp_a) begin
				resp_a <= 1'b0;
				a_held = data_busy;
				a_wait = random_below(4);
			end else if (a_held) begin
				a_held = data_busy;
			end else if (a_wait > 0) begin
				a_wait--;
			end else begin
				resp_a <= 1'b1;
				rdata_a <= imem[address_a[9:2]];
			end
			if (resp_b) begin
				resp_b <= 1'b0;
				b_wait = random_below(4);
			end else if (read_b || write) begin
				if (b_wait > 0) begin
					b_wait--;
				end else begin
					resp_b <= 1'b1;
					rdata_b <= dmem[address_b[7:2]];
					if (write)
						dmem[address_b[7:2]] = wdata;
				end
			end
		end
	end

	initial begin
		seed = 32'hfa21_bdae;
		clk = 1'b0;
		rst_n = 1'b0;
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = 32'd0;
		rdata_b = 32'd0;
		for (int i = 0; i < 64; i++)
			dmem[i] = 32'd0;
		build_program();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait (done);
		$display("Store checks finished with %0d errors", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial begin
		#(time_limit + 4 * period);
		$display("Timeout: stores still missing after %0d time units, %0d errors so far",
			time_limit, errors);
		$display("Checks failed");
		$finish;
	end

endmodule

/* verification/cpu_datapath_checker.sv */
module cpu_datapath_checker import rv32i_types::*; #(
	parameter int n_instr = 200
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        read_a,
	input  logic [31:0] address_a,
	input  logic        read_b,
	input  logic        write,
	input  logic        resp_b,
	input  logic [3:0]  wmask,
	input  logic [31:0] address_b,
	input  logic [31:0] wdata,
	output int          errors,
	output logic        done
);

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int seen, cycles, n_stores;

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Instruction-level run of the program
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [64];
		logic [31:0] pc, next_pc, ins, a, b, i_imm, s_imm, b_imm, res;
		logic wr;
		int i, steps;
		for (i = 0; i < 32; i++)
			regs[i] = 32'd0;
		for (i = 0; i < 64; i++)
			mem[i] = 32'd0;
		pc = 32'd0;
		for (steps = 0; steps < n_instr; steps++) begin
			ins = cpu_datapath_tb.imem[pc[9:2]];
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			i_imm = {{20{ins[31]}}, ins[31:20]};
			s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			next_pc = pc + 32'd4;
			wr = 1'b1;
			res = 32'd0;
			case (ins[6:0])
				op_reg: res = alu_result(ins[14:12], ins[30], a, b);
				op_imm: res = alu_result(ins[14:12], 1'b0, a, i_imm);
				op_lui: res = {ins[31:12], 12'h000};
				op_load: res = mem[(a + i_imm) >> 2];
				op_store: begin
					wr = 1'b0;
					mem[(a + s_imm) >> 2] = b;
					exp_addr.push_back(a + s_imm);
					exp_data.push_back(b);
				end
				default: begin
					wr = 1'b0;
					if ((ins[14:12] == f3_bne) ? (a != b) : (a == b))
						next_pc = pc + b_imm;
				end
			endcase
			if (wr && ins[11:7] != 5'd0)
				regs[ins[11:7]] = res;
			if (next_pc == pc)
				break;
			pc = next_pc;
		end
	endtask

	initial begin
		errors = 0;
		seen = 0;
		cycles = 0;
		done = 1'b0;
		@(posedge rst_n);
		run_model();
		n_stores = exp_addr.size();
		wait (seen == n_stores);
		// Room for a stray write to show up
		repeat (20) @(posedge clk);
		done = 1'b1;
	end

	// Nothing can reach memory during the first cycles after reset
	always @(posedge clk) begin
		if ((!rst_n || cycles < 3) && (read_b || write)) begin
			$display("%0t: data request raised before any load or store reached memory", $time);
			errors++;
		end
		if (rst_n)
			cycles++;
	end

	// Fetch request stays up out of reset
	always @(posedge clk) begin
		if (rst_n && read_a !== 1'b1) begin
			$display("** Error at %0t: read_a expected %b, observed %b", $time, 1'b1, read_a);
			errors++;
		end
		if (rst_n && (address_a >= 32'd1024 || address_a[1:0] != 2'b00)) begin
			$display("%0t: fetch from %h lies outside the instruction words", $time, address_a);
			errors++;
		end
	end

	always @(posedge clk) begin
		if (rst_n && resp_b && write) begin
			if (seen >= exp_addr.size()) begin
				$display("%0t: extra data write to %h after the last expected store",
					$time, address_b);
				errors++;
			end else begin
				if (address_b !== exp_addr[seen]) begin
					$display("** Error at %0t: address_b expected %h, observed %h",
						$time, exp_addr[seen], address_b);
					errors++;
				end
				if (wdata !== exp_data[seen]) begin
					$display("** Error at %0t: wdata expected %h, observed %h",
						$time, exp_data[seen], wdata);
					errors++;
				end
				if (wmask !== 4'b1111) begin
					$display("** Error at %0t: wmask expected %h, observed %h",
						$time, 4'b1111, wmask);
					errors++;
				end
				seen++;
			end
		end
		if (rst_n && resp_b && read_b && (address_b >= 32'd256 || address_b[1:0] != 2'b00)) begin
			$display("%0t: load from %h lies outside the program's data words", $time, address_b);
			errors++;
		end
	end

endmodule

/* logic/cpu_datapath.sv */
module cpu_datapath import rv32i_types::*; #(
	parameter logic [31:0] pc_reset = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        resp_a,
	input  logic        resp_b,
	input  logic [31:0] rdata_a,
	input  logic [31:0] rdata_b,
	output logic        read_a,
	output logic        read_b,
	output logic        write,
	output logic [3:0]  wmask,
	output logic [31:0] address_a,
	output logic [31:0] address_b,
	output logic [31:0] wdata
);

	logic advance, mem_busy, instr_held;
	logic [31:0] instr_hold, instr_word;
	logic stall, redirect;
	logic [31:0] target;
	logic [31:0] ifid_instr, ifid_pc;
	logic ifid_valid;
	logic [31:0] idex_rs1_val, idex_rs2_val, idex_imm, idex_pc;
	logic [4:0] idex_rs1, idex_rs2, idex_rd;
	alu_ops idex_aluop;
	wb_sel_t idex_wb_sel, exmem_wb_sel;
	logic idex_uses_imm, idex_load, idex_store, idex_branch, idex_bne, idex_reg_write;
	logic [31:0] exmem_result, exmem_store_data, exmem_imm;
	logic [4:0] exmem_rd, wb_rd;
	logic exmem_reg_write, exmem_load, exmem_store;
	logic [31:0] wb_data;
	logic wb_write;

	// Instruction response kept while the data side is still busy
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr_held <= 1'b0;
		else if (advance)
			instr_held <= 1'b0;
		else if (resp_a)
			instr_held <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (resp_a && !instr_held)
			instr_hold <= rdata_a;
	end

	assign instr_word = instr_held ? instr_hold : rdata_a;
	assign advance = (resp_a || instr_held) && !mem_busy;

	cpu_fetch #(
		.pc_reset(pc_reset)
	) u_fetch (
		.clk, .rst_n, .advance, .stall, .redirect, .target,
		.rdata_a(instr_word),
		.address_a, .read_a, .ifid_instr, .ifid_pc, .ifid_valid
	);

	cpu_decode u_decode (
		.clk, .rst_n, .advance,
		.flush(redirect),
		.ifid_instr, .ifid_pc, .ifid_valid, .wb_rd, .wb_data, .wb_write,
		.stall, .idex_rs1_val, .idex_rs2_val, .idex_rs1, .idex_rs2, .idex_rd,
		.idex_imm, .idex_aluop, .idex_uses_imm, .idex_load, .idex_store,
		.idex_branch, .idex_bne, .idex_reg_write, .idex_wb_sel, .idex_pc
	);

	cpu_execute u_execute (
		.clk, .rst_n, .advance,
		.idex_rs1_val, .idex_rs2_val, .idex_rs1, .idex_rs2, .idex_rd,
		.idex_imm, .idex_aluop, .idex_uses_imm, .idex_load, .idex_store,
		.idex_branch, .idex_bne, .idex_reg_write, .idex_wb_sel, .idex_pc,
		.wb_rd, .wb_data, .wb_write,
		.redirect, .target, .exmem_result, .exmem_store_data, .exmem_rd,
		.exmem_reg_write, .exmem_load, .exmem_store, .exmem_wb_sel, .exmem_imm
	);

	cpu_memory u_memory (
		.clk, .rst_n, .advance,
		.exmem_result, .exmem_store_data, .exmem_rd, .exmem_reg_write,
		.exmem_load, .exmem_store, .exmem_wb_sel, .exmem_imm,
		.resp_b, .rdata_b,
		.address_b, .read_b, .write, .wmask, .wdata,
		.wb_rd, .wb_data, .wb_write, .mem_busy
	);

endmodule

/* logic/cpu_memory.sv */
module cpu_memory import rv32i_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        advance,
	input  logic [31:0] exmem_result,
	input  logic [31:0] exmem_store_data,
	input  logic [4:0]  exmem_rd,
	input  logic        exmem_reg_write,
	input  logic        exmem_load,
	input  logic        exmem_store,
	input  wb_sel_t     exmem_wb_sel,
	input  logic [31:0] exmem_imm,
	input  logic        resp_b,
	input  logic [31:0] rdata_b,
	output logic [31:0] address_b,
	output logic        read_b,
	output logic        write,
	output logic [3:0]  wmask,
	output logic [31:0] wdata,
	output logic [4:0]  wb_rd,
	output logic [31:0] wb_data,
	output logic        wb_write,
	output logic        mem_busy
);

	logic done;
	logic [31:0] rdata_hold, mem_rdata;
	logic [31:0] memwb_result, memwb_imm, memwb_rdata;
	wb_sel_t memwb_wb_sel;

	// Request drops once answered, even if the pipeline is still frozen
	assign read_b = exmem_load && !done;
	assign write = exmem_store && !done;
	assign address_b = exmem_result;
	assign wdata = exmem_store_data;
	assign wmask = 4'b1111;
	assign mem_busy = (read_b || write) && !resp_b;
	assign mem_rdata = resp_b ? rdata_b : rdata_hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (advance)
			done <= 1'b0;
		else if (resp_b)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (resp_b)
			rdata_hold <= rdata_b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_write <= 1'b0;
		else if (advance)
			wb_write <= exmem_reg_write;
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_rd <= exmem_rd;
			memwb_wb_sel <= exmem_wb_sel;
			memwb_result <= exmem_result;
			memwb_imm <= exmem_imm;
			memwb_rdata <= mem_rdata;
		end
	end

	always_comb begin
		case (memwb_wb_sel)
			wb_mem:  wb_data = memwb_rdata;
			wb_imm:  wb_data = memwb_imm;
			default: wb_data = memwb_result;
		endcase
	end

endmodule

/* logic/cpu_execute.sv */
module cpu_execute import rv32i_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        advance,
	input  logic [31:0] idex_rs1_val,
	input  logic [31:0] idex_rs2_val,
	input  logic [4:0]  idex_rs1,
	input  logic [4:0]  idex_rs2,
	input  logic [4:0]  idex_rd,
	input  logic [31:0] idex_imm,
	input  alu_ops      idex_aluop,
	input  logic        idex_uses_imm,
	input  logic        idex_load,
	input  logic        idex_store,
	input  logic        idex_branch,
	input  logic        idex_bne,
	input  logic        idex_reg_write,
	input  wb_sel_t     idex_wb_sel,
	input  logic [31:0] idex_pc,
	input  logic [4:0]  wb_rd,
	input  logic [31:0] wb_data,
	input  logic        wb_write,
	output logic        redirect,
	output logic [31:0] target,
	output logic [31:0] exmem_result,
	output logic [31:0] exmem_store_data,
	output logic [4:0]  exmem_rd,
	output logic        exmem_reg_write,
	output logic        exmem_load,
	output logic        exmem_store,
	output wb_sel_t     exmem_wb_sel,
	output logic [31:0] exmem_imm
);

	logic [31:0] exmem_fwd, rs1_fwd, rs2_fwd, op_b, alu_out;
	logic ex_hit1, ex_hit2, wb_hit1, wb_hit2, equal;

	// lui results sit in the immediate field until writeback
	assign exmem_fwd = (exmem_wb_sel == wb_imm) ? exmem_imm : exmem_result;

	assign ex_hit1 = exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs1;
	assign ex_hit2 = exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs2;
	assign wb_hit1 = wb_write && wb_rd != 5'd0 && wb_rd == idex_rs1;
	assign wb_hit2 = wb_write && wb_rd != 5'd0 && wb_rd == idex_rs2;

	assign rs1_fwd = ex_hit1 ? exmem_fwd : wb_hit1 ? wb_data : idex_rs1_val;
	assign rs2_fwd = ex_hit2 ? exmem_fwd : wb_hit2 ? wb_data : idex_rs2_val;
	assign op_b = idex_uses_imm ? idex_imm : rs2_fwd;

	always_comb begin
		case (idex_aluop)
			alu_add: alu_out = rs1_fwd + op_b;
			alu_sub: alu_out = rs1_fwd - op_b;
			alu_and: alu_out = rs1_fwd & op_b;
			alu_or:  alu_out = rs1_fwd | op_b;
			alu_xor: alu_out = rs1_fwd ^ op_b;
			alu_slt: alu_out = {31'd0, $signed(rs1_fwd) < $signed(op_b)};
			alu_sll: alu_out = rs1_fwd << op_b[4:0];
			alu_srl: alu_out = rs1_fwd >> op_b[4:0];
			default: alu_out = 32'd0;
		endcase
	end

	// Branch resolves here without prediction
	assign equal = (rs1_fwd == rs2_fwd);
	assign redirect = idex_branch && (idex_bne ? !equal : equal);
	assign target = idex_pc + idex_imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem_reg_write <= 1'b0;
			exmem_load <= 1'b0;
			exmem_store <= 1'b0;
		end else if (advance) begin
			exmem_reg_write <= idex_reg_write;
			exmem_load <= idex_load;
			exmem_store <= idex_store;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			exmem_result <= alu_out;
			exmem_store_data <= rs2_fwd;
			exmem_rd <= idex_rd;
			exmem_wb_sel <= idex_wb_sel;
			exmem_imm <= idex_imm;
		end
	end

endmodule

/* logic/cpu_decode.sv */
module cpu_decode import rv32i_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        advance,
	input  logic        flush,
	input  logic [31:0] ifid_instr,
	input  logic [31:0] ifid_pc,
	input  logic        ifid_valid,
	input  logic [4:0]  wb_rd,
	input  logic [31:0] wb_data,
	input  logic        wb_write,
	output logic        stall,
	output logic [31:0] idex_rs1_val,
	output logic [31:0] idex_rs2_val,
	output logic [4:0]  idex_rs1,
	output logic [4:0]  idex_rs2,
	output logic [4:0]  idex_rd,
	output logic [31:0] idex_imm,
	output alu_ops      idex_aluop,
	output logic        idex_uses_imm,
	output logic        idex_load,
	output logic        idex_store,
	output logic        idex_branch,
	output logic        idex_bne,
	output logic        idex_reg_write,
	output wb_sel_t     idex_wb_sel,
	output logic [31:0] idex_pc
);

	rv32i_opcode opcode;
	logic [2:0] funct3;
	logic [4:0] rs1, rs2, rd;
	logic [31:0] i_imm, s_imm, b_imm, u_imm, imm;
	logic [31:0] regs [32];
	logic [31:0] rs1_val, rs2_val;
	alu_ops arith_op, aluop;
	wb_sel_t wb_sel;
	logic uses_imm, is_load, is_store, is_branch, reg_write;
	logic uses_rs1, uses_rs2, bubble;

	assign opcode = rv32i_opcode'(ifid_instr[6:0]);
	assign funct3 = ifid_instr[14:12];
	assign rd = ifid_instr[11:7];
	assign rs1 = ifid_instr[19:15];
	assign rs2 = ifid_instr[24:20];

	assign i_imm = {{20{ifid_instr[31]}}, ifid_instr[31:20]};
	assign s_imm = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
	assign b_imm = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
		ifid_instr[30:25], ifid_instr[11:8], 1'b0};
	assign u_imm = {ifid_instr[31:12], 12'h000};

	// Register file written from writeback with write-through
	always_ff @(posedge clk) begin
		if (wb_write && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

	assign rs1_val = (rs1 == 5'd0) ? 32'd0 :
		(wb_write && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_val = (rs2 == 5'd0) ? 32'd0 :
		(wb_write && wb_rd == rs2) ? wb_data : regs[rs2];

	always_comb begin
		case (funct3)
			f3_add: arith_op = (opcode == op_reg && ifid_instr[30]) ? alu_sub : alu_add;
			f3_sll: arith_op = alu_sll;
			f3_slt: arith_op = alu_slt;
			f3_xor: arith_op = alu_xor;
			f3_srl: arith_op = alu_srl;
			f3_or:  arith_op = alu_or;
			f3_and: arith_op = alu_and;
			default: arith_op = alu_add;
		endcase
	end

	always_comb begin
		aluop = alu_add;
		uses_imm = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		reg_write = 1'b0;
		wb_sel = wb_alu;
		imm = i_imm;
		case (opcode)
			op_reg: begin
				aluop = arith_op;
				reg_write = 1'b1;
			end
			op_imm: begin
				aluop = arith_op;
				uses_imm = 1'b1;
				reg_write = 1'b1;
			end
			op_lui: begin
				imm = u_imm;
				wb_sel = wb_imm;
				reg_write = 1'b1;
			end
			op_load: begin
				uses_imm = 1'b1;
				is_load = (funct3 == f3_word);
				reg_write = is_load;
				wb_sel = wb_mem;
			end
			op_store: begin
				imm = s_imm;
				uses_imm = 1'b1;
				is_store = (funct3 == f3_word);
			end
			op_br: begin
				imm = b_imm;
				is_branch = (funct3 == f3_beq) || (funct3 == f3_bne);
			end
			default: ;
		endcase
	end

	// Load-use hazard against the instruction now in execute
	assign uses_rs1 = (opcode != op_lui);
	assign uses_rs2 = (opcode == op_reg) || (opcode == op_store) || (opcode == op_br);
	assign stall = ifid_valid && idex_load && idex_rd != 5'd0 &&
		((uses_rs1 && idex_rd == rs1) || (uses_rs2 && idex_rd == rs2));

	assign bubble = stall || flush || !ifid_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex_load <= 1'b0;
			idex_store <= 1'b0;
			idex_branch <= 1'b0;
			idex_reg_write <= 1'b0;
		end else if (advance) begin
			idex_load <= is_load && !bubble;
			idex_store <= is_store && !bubble;
			idex_branch <= is_branch && !bubble;
			idex_reg_write <= reg_write && !bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			idex_rs1_val <= rs1_val;
			idex_rs2_val <= rs2_val;
			idex_rs1 <= rs1;
			idex_rs2 <= rs2;
			idex_rd <= rd;
			idex_imm <= imm;
			idex_aluop <= aluop;
			idex_uses_imm <= uses_imm;
			idex_bne <= (funct3 == f3_bne);
			idex_wb_sel <= wb_sel;
			idex_pc <= ifid_pc;
		end
	end

endmodule

/* logic/cpu_fetch.sv */
module cpu_fetch import rv32i_types::*; #(
	parameter logic [31:0] pc_reset = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        advance,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] target,
	input  logic [31:0] rdata_a,
	output logic [31:0] address_a,
	output logic        read_a,
	output logic [31:0] ifid_instr,
	output logic [31:0] ifid_pc,
	output logic        ifid_valid
);

	logic [31:0] pc;

	assign address_a = pc;
	assign read_a = 1'b1;

	// Redirect wins over a load-use hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= pc_reset;
			ifid_instr <= nop_instr;
			ifid_valid <= 1'b0;
		end else if (advance) begin
			if (redirect) begin
				pc <= target;
				ifid_instr <= nop_instr;
				ifid_valid <= 1'b0;
			end else if (!stall) begin
				pc <= pc + 32'd4;
				ifid_instr <= rdata_a;
				ifid_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !stall && !redirect)
			ifid_pc <= pc;
	end

endmodule

/* logic/rv32i_types.sv */
package rv32i_types;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg   = 7'b0110011,
		op_imm   = 7'b0010011,
		op_lui   = 7'b0110111,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_br    = 7'b1100011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl
	} alu_ops;

	// Writeback source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_imm
	} wb_sel_t;

	// funct3 codes
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;

	// addi x0, x0, 0
	localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage
